/* Bender.yml */
package:
  name: line_buffer

sources:
  - cpu_bus_pkg.sv
  - line_bus_pkg.sv
  - strobe_decode.sv
  - line_store.sv
  - burst_counter.sv
  - line_buffer_fsm.sv
  - burst_memory.sv
  - line_buffer_top.sv
  - target: simulation
    files:
      - tb_line_buffer.sv

/* burst_counter.sv */
`timescale 1ns/100ps
`default_nettype none

module burst_counter #(
    parameter int BUFFER_LENGTH = 16,

    localparam int OFFSET_BITS = $clog2(BUFFER_LENGTH)
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   okay,
    output logic [OFFSET_BITS-1:0] offset
);

    localparam logic [OFFSET_BITS-1:0] LAST_BEAT = OFFSET_BITS'(BUFFER_LENGTH - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            offset <= '0;
        end else if (okay) begin
            // back to zero so a refill can follow a writeback
            if (offset == LAST_BEAT) begin
                offset <= '0;
            end else begin
                offset <= offset + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* burst_memory.sv */
`timescale 1ns/100ps
`default_nettype none

module burst_memory
    import cpu_bus_pkg::*;
    import line_bus_pkg::*;
#(
    parameter int MEM_WORDS     = 1024,
    parameter int BUFFER_LENGTH = 16,

    localparam int MEM_BITS = $clog2(MEM_WORDS),
    localparam int CNT_BITS = $clog2(BUFFER_LENGTH) + 1
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       bus_valid,
    input  logic       bus_write,
    input  addr_t      bus_addr,
    input  burst_len_t bus_len,
    input  word_t      bus_wdata,
    output logic       bus_okay,
    output logic       bus_last,
    output word_t      bus_rdata
);

    word_t mem [MEM_WORDS];

    logic active;
    logic done;
    logic start;

    logic                cur_write;
    burst_len_t          cur_len;
    logic [MEM_BITS-1:0] base;
    logic [CNT_BITS-1:0] cnt;
    logic [CNT_BITS-1:0] last_cnt;
    logic [MEM_BITS-1:0] word_index;

    // each word holds its byte address with the top byte flipped
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = addr_t'(i * BYTES_PER_WORD) ^ 32'hff00_0000;
        end
    end

    // a new burst also starts when the direction turns around
    assign start = bus_valid && !active && (!done || bus_write != cur_write);

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            done   <= 1'b0;
        end else if (start) begin
            active <= 1'b1;
            done   <= 1'b0;
        end else if (active && bus_last) begin
            active <= 1'b0;
            done   <= 1'b1;
        end else if (!bus_valid) begin
            done <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            cur_write <= bus_write;
            cur_len   <= bus_len;
            base      <= bus_addr[ALIGN_BITS +: MEM_BITS];
            cnt       <= '0;
        end else if (active) begin
            cnt <= cnt + 1'b1;
        end
    end

    assign last_cnt   = CNT_BITS'((1 << cur_len) - 1);
    assign word_index = base + MEM_BITS'(cnt);

    always @(posedge clk) begin
        if (active && cur_write) begin
            mem[word_index] <= bus_wdata;
        end
    end

    assign bus_okay  = active;
    assign bus_last  = active && (cnt == last_cnt);
    assign bus_rdata = mem[word_index];

endmodule

`default_nettype wire

/* cpu_bus_pkg.sv */
`default_nettype none

package cpu_bus_pkg;

    localparam int BITS_PER_BYTE  = 8;
    localparam int BYTES_PER_WORD = 4;
    localparam int BITS_PER_WORD  = BITS_PER_BYTE * BYTES_PER_WORD;

    typedef logic [BITS_PER_BYTE-1:0] byte_t;
    typedef logic [BITS_PER_WORD-1:0] word_t;

    // access size, log2 of the byte count
    typedef logic [1:0] size_t;

    localparam size_t SIZE_BYTE = 2'd0;
    localparam size_t SIZE_HALF = 2'd1;
    localparam size_t SIZE_WORD = 2'd2;

    typedef logic [BYTES_PER_WORD-1:0] strobe_t;

    // one word seen as bytes or as a whole
    typedef union packed {
        byte_t [BYTES_PER_WORD-1:0] bytes;
        word_t                      word;
    } word_view_t;

endpackage

`default_nettype wire

/* line_buffer_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

module line_buffer_fsm
    import cpu_bus_pkg::*;
    import line_bus_pkg::*;
#(
    parameter int BUFFER_LENGTH = 16,

    localparam int OFFSET_BITS = $clog2(BUFFER_LENGTH),
    localparam int TAG_BITS    = ADDR_BITS - OFFSET_BITS - ALIGN_BITS
) (
    input  logic                   clk,
    input  logic                   reset,

    // processor port
    input  logic                   req,
    input  logic                   wr,
    input  size_t                  size,
    input  addr_t                  addr,
    input  word_t                  wdata,
    output logic                   addr_ok,
    output logic                   data_ok,
    output word_t                  rdata,

    input  logic [OFFSET_BITS-1:0] beat_offset,
    input  word_t                  store_read_data,

    // line store write controls
    output logic                   hit_write,
    output logic [OFFSET_BITS-1:0] hit_index,
    output strobe_t                hit_strobe,
    output word_t                  hit_wdata,
    output logic                   fill,
    output strobe_t                fill_strobe,
    output word_t                  fill_wdata,

    // burst bus
    output logic                   bus_valid,
    output logic                   bus_write,
    output addr_t                  bus_addr,
    output burst_len_t             bus_len,
    input  logic                   bus_okay,
    input  logic                   bus_last,
    input  word_t                  bus_rdata
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_REFILL,
        ST_WRITEBACK
    } state_t;

    state_t state;
    logic   valid;
    logic   dirty;

    logic [TAG_BITS-1:0] tag;

    logic  saved_wr;
    size_t saved_size;
    addr_t saved_addr;
    word_t saved_wdata;

    logic [TAG_BITS-1:0]    req_tag;
    logic [TAG_BITS-1:0]    saved_tag;
    logic [OFFSET_BITS-1:0] saved_index;
    logic                   tag_hit;
    logic                   offset_hit;
    strobe_t                req_strobe;
    strobe_t                saved_strobe;
    strobe_t                merge_strobe;

    word_view_t beat_view;
    word_view_t saved_view;
    word_view_t merged_view;

    assign req_tag     = addr[ADDR_BITS-1 -: TAG_BITS];
    assign saved_tag   = saved_addr[ADDR_BITS-1 -: TAG_BITS];
    assign saved_index = saved_addr[ALIGN_BITS +: OFFSET_BITS];

    assign tag_hit    = valid && (tag == req_tag);
    assign offset_hit = (beat_offset == saved_index);

    strobe_decode u_req_strobe (
        .size   (size),
        .offset (addr[ALIGN_BITS-1:0]),
        .strobe (req_strobe)
    );

    strobe_decode u_saved_strobe (
        .size   (saved_size),
        .offset (saved_addr[ALIGN_BITS-1:0]),
        .strobe (saved_strobe)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
            valid <= 1'b0;
            dirty <= 1'b0;
        end else begin
            unique case (state)
                ST_IDLE: begin
                    if (req && tag_hit) begin
                        if (wr) begin
                            dirty <= 1'b1;
                        end
                    end else if (req) begin
                        state <= dirty ? ST_WRITEBACK : ST_REFILL;
                    end
                end
                ST_WRITEBACK: begin
                    if (bus_last) begin
                        state <= ST_REFILL;
                    end
                end
                ST_REFILL: begin
                    if (bus_last) begin
                        state <= ST_IDLE;
                        valid <= 1'b1;
                        tag   <= saved_tag;
                        // write miss leaves its merged word behind
                        dirty <= saved_wr;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // miss request held for the burst
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req && !tag_hit) begin
            saved_wr    <= wr;
            saved_size  <= size;
            saved_addr  <= addr;
            saved_wdata <= wdata;
        end
    end

    assign merge_strobe = saved_wr ? saved_strobe : '0;

    assign beat_view  = bus_rdata;
    assign saved_view = saved_wdata;

    always_comb begin
        for (int i = 0; i < BYTES_PER_WORD; i++) begin
            merged_view.bytes[i] = merge_strobe[i] ? saved_view.bytes[i]
                                                   : beat_view.bytes[i];
        end
    end

    assign addr_ok = (state == ST_IDLE);
    assign data_ok = (state == ST_IDLE && req && tag_hit) ||
                     (state == ST_REFILL && bus_okay && offset_hit);
    // forward the refill beat straight through
    assign rdata   = (state == ST_IDLE) ? store_read_data : merged_view.word;

    assign hit_write   = (state == ST_IDLE) && req && wr && tag_hit;
    assign hit_index   = addr[ALIGN_BITS +: OFFSET_BITS];
    assign hit_strobe  = req_strobe;
    assign hit_wdata   = wdata;
    assign fill        = (state == ST_REFILL) && bus_okay;
    assign fill_strobe = offset_hit ? merge_strobe : '0;
    assign fill_wdata  = saved_wdata;

    assign bus_valid = (state != ST_IDLE);
    assign bus_write = (state == ST_WRITEBACK);
    assign bus_len   = burst_len_t'(OFFSET_BITS);
    // old tag goes out, new tag comes in
    assign bus_addr  = {(state == ST_WRITEBACK) ? tag : saved_tag,
                        {(OFFSET_BITS + ALIGN_BITS){1'b0}}};

endmodule

`default_nettype wire

/* line_buffer_top.sv */
`timescale 1ns/100ps
`default_nettype none

module line_buffer_top
    import cpu_bus_pkg::*;
    import line_bus_pkg::*;
#(
    parameter int BUFFER_LENGTH = 16,
    parameter int MEM_WORDS     = 1024,

    localparam int OFFSET_BITS = $clog2(BUFFER_LENGTH)
) (
    input  logic  clk,
    input  logic  reset,
    input  logic  req,
    input  logic  wr,
    input  size_t size,
    input  addr_t addr,
    input  word_t wdata,
    output logic  addr_ok,
    output logic  data_ok,
    output word_t rdata
);

    logic [OFFSET_BITS-1:0] beat_offset;
    logic [OFFSET_BITS-1:0] hit_index;
    word_t                  store_read_data;
    logic                   hit_write;
    strobe_t                hit_strobe;
    word_t                  hit_wdata;
    logic                   fill;
    strobe_t                fill_strobe;
    word_t                  fill_wdata;

    logic       bus_valid;
    logic       bus_write;
    addr_t      bus_addr;
    burst_len_t bus_len;
    word_t      bus_wdata;
    logic       bus_okay;
    logic       bus_last;
    word_t      bus_rdata;

    line_buffer_fsm #(
        .BUFFER_LENGTH (BUFFER_LENGTH)
    ) u_fsm (
        .clk             (clk),
        .reset           (reset),
        .req             (req),
        .wr              (wr),
        .size            (size),
        .addr            (addr),
        .wdata           (wdata),
        .addr_ok         (addr_ok),
        .data_ok         (data_ok),
        .rdata           (rdata),
        .beat_offset     (beat_offset),
        .store_read_data (store_read_data),
        .hit_write       (hit_write),
        .hit_index       (hit_index),
        .hit_strobe      (hit_strobe),
        .hit_wdata       (hit_wdata),
        .fill            (fill),
        .fill_strobe     (fill_strobe),
        .fill_wdata      (fill_wdata),
        .bus_valid       (bus_valid),
        .bus_write       (bus_write),
        .bus_addr        (bus_addr),
        .bus_len         (bus_len),
        .bus_okay        (bus_okay),
        .bus_last        (bus_last),
        .bus_rdata       (bus_rdata)
    );

    burst_counter #(
        .BUFFER_LENGTH (BUFFER_LENGTH)
    ) u_counter (
        .clk    (clk),
        .reset  (reset),
        .okay   (bus_okay),
        .offset (beat_offset)
    );

    // processor reads share the hit index
    line_store #(
        .BUFFER_LENGTH (BUFFER_LENGTH)
    ) u_store (
        .clk         (clk),
        .hit_write   (hit_write),
        .hit_index   (hit_index),
        .hit_strobe  (hit_strobe),
        .hit_wdata   (hit_wdata),
        .fill        (fill),
        .fill_index  (beat_offset),
        .fill_strobe (fill_strobe),
        .fill_wdata  (fill_wdata),
        .fill_rdata  (bus_rdata),
        .read_index  (hit_index),
        .read_data   (store_read_data),
        .beat_data   (bus_wdata)
    );

    burst_memory #(
        .MEM_WORDS     (MEM_WORDS),
        .BUFFER_LENGTH (BUFFER_LENGTH)
    ) u_memory (
        .clk       (clk),
        .reset     (reset),
        .bus_valid (bus_valid),
        .bus_write (bus_write),
        .bus_addr  (bus_addr),
        .bus_len   (bus_len),
        .bus_wdata (bus_wdata),
        .bus_okay  (bus_okay),
        .bus_last  (bus_last),
        .bus_rdata (bus_rdata)
    );

endmodule

`default_nettype wire

/* line_bus_pkg.sv */
`default_nettype none

package line_bus_pkg;

    localparam int ADDR_BITS = 32;

    // byte offset bits inside a word
    localparam int ALIGN_BITS = 2;

    typedef logic [ADDR_BITS-1:0] addr_t;

    // burst length as log2 of the beat count
    typedef logic [3:0] burst_len_t;

endpackage

`default_nettype wire

/* line_store.sv */
`timescale 1ns/100ps
`default_nettype none

module line_store
    import cpu_bus_pkg::*;
#(
    parameter int BUFFER_LENGTH = 16,

    localparam int OFFSET_BITS = $clog2(BUFFER_LENGTH)
) (
    input  logic                   clk,

    // processor side write on a hit
    input  logic                   hit_write,
    input  logic [OFFSET_BITS-1:0] hit_index,
    input  strobe_t                hit_strobe,
    input  word_t                  hit_wdata,

    // refill beat from the bus
    input  logic                   fill,
    input  logic [OFFSET_BITS-1:0] fill_index,
    input  strobe_t                fill_strobe,
    input  word_t                  fill_wdata,
    input  word_t                  fill_rdata,

    input  logic [OFFSET_BITS-1:0] read_index,
    output word_t                  read_data,
    output word_t                  beat_data
);

    word_view_t mem [BUFFER_LENGTH];

    word_view_t hit_view;
    word_view_t fill_view;
    word_view_t bus_view;

    assign hit_view  = hit_wdata;
    assign fill_view = fill_wdata;
    assign bus_view  = fill_rdata;

    always_ff @(posedge clk) begin
        if (hit_write) begin
            for (int i = 0; i < BYTES_PER_WORD; i++) begin
                if (hit_strobe[i]) begin
                    mem[hit_index].bytes[i] <= hit_view.bytes[i];
                end
            end
        end else if (fill) begin
            // saved write bytes win over the bus beat
            for (int i = 0; i < BYTES_PER_WORD; i++) begin
                mem[fill_index].bytes[i] <= fill_strobe[i] ? fill_view.bytes[i]
                                                           : bus_view.bytes[i];
            end
        end
    end

    assign read_data = mem[read_index].word;

    // word leaving on a writeback beat
    assign beat_data = mem[fill_index].word;

endmodule

`default_nettype wire

/* strobe_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module strobe_decode
    import cpu_bus_pkg::*;
(
    input  size_t       size,
    input  logic [1:0]  offset,
    output strobe_t     strobe
);

    always_comb begin
        unique case (size)
            SIZE_BYTE: begin
                strobe = strobe_t'(4'b0001 << offset);
            end
            SIZE_HALF: begin
                // halfwords sit on even byte offsets
                strobe = strobe_t'(4'b0011 << {offset[1], 1'b0});
            end
            default: begin
                strobe = '1;
            end
        endcase
    end

endmodule

`default_nettype wire

/* tb.f */
cpu_bus_pkg.sv
line_bus_pkg.sv
strobe_decode.sv
line_store.sv
burst_counter.sv
line_buffer_fsm.sv
burst_memory.sv
line_buffer_top.sv
tb_line_buffer.sv

/* tb_line_buffer.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_line_buffer
    import cpu_bus_pkg::*;
    import line_bus_pkg::*;
();

    localparam int BUFFER_LENGTH   = 16;
    localparam int MEM_WORDS       = 1024;
    localparam int OFFSET_BITS     = $clog2(BUFFER_LENGTH);
    localparam int MEM_BITS        = $clog2(MEM_WORDS);
    localparam int LINE_BYTES      = BUFFER_LENGTH * BYTES_PER_WORD;
    localparam int RESET_CYCLES    = 4;
    localparam int RANDOM_ACCESSES = 80;
    // acceptance, a full writeback, a full refill and some slack
    localparam int WORST_CYCLES    = 2 * (BUFFER_LENGTH + 1) + 4;

    localparam addr_t LINE_A = 32'h0000_0100;
    localparam addr_t LINE_B = 32'h0000_0340;
    localparam addr_t LINE_C = 32'h0000_07c0;
    localparam addr_t LINE_D = 32'h0000_0f00;

    logic  clk;
    logic  reset;
    logic  req;
    logic  wr;
    size_t size;
    addr_t addr;
    word_t wdata;
    logic  addr_ok;
    logic  data_ok;
    word_t rdata;

    word_t shadow [MEM_WORDS];

    // request the DUT is working on
    logic  cur_wr;
    addr_t cur_addr;
    word_t expect_word;
    logic  hit_expected;
    logic  outstanding;

    // what the single line should hold
    logic  line_valid;
    addr_t line_tag;

    logic [31:0] rng_state;
    int          errors;
    int          issued;
    int          hits;
    int          misses;
    int          cycles;

    line_buffer_top #(
        .BUFFER_LENGTH (BUFFER_LENGTH),
        .MEM_WORDS     (MEM_WORDS)
    ) u_line_buffer_top (
        .clk     (clk),
        .reset   (reset),
        .req     (req),
        .wr      (wr),
        .size    (size),
        .addr    (addr),
        .wdata   (wdata),
        .addr_ok (addr_ok),
        .data_ok (data_ok),
        .rdata   (rdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // byte address of the word with its top byte inverted
    function automatic word_t initial_word(input int index);
        addr_t byte_addr;
        byte_addr = addr_t'(index) << ALIGN_BITS;
        return {~byte_addr[31:24], byte_addr[23:0]};
    endfunction

    function automatic addr_t line_tag_of(input addr_t a);
        return a >> (OFFSET_BITS + ALIGN_BITS);
    endfunction

    function automatic int shadow_index(input addr_t a);
        return int'(a[ALIGN_BITS +: MEM_BITS]);
    endfunction

    // an access covers the naturally aligned group of its size
    function automatic strobe_t lanes(input size_t sz, input logic [1:0] off);
        int      count;
        int      first;
        strobe_t mask;
        count = (sz == SIZE_BYTE) ? 1 : (sz == SIZE_HALF) ? 2 : 4;
        first = (int'(off) / count) * count;
        mask  = '0;
        for (int i = 0; i < BYTES_PER_WORD; i++) begin
            if (i >= first && i < first + count) begin
                mask[i] = 1'b1;
            end
        end
        return mask;
    endfunction

    // write bytes replace the old ones only on the covered lanes
    function automatic word_t merge_write(input word_t old, input size_t sz,
                                          input logic [1:0] off, input word_t d);
        strobe_t mask;
        word_t   w;
        mask = lanes(sz, off);
        w    = old;
        for (int i = 0; i < BYTES_PER_WORD; i++) begin
            if (mask[i]) begin
                w[8*i +: 8] = d[8*i +: 8];
            end
        end
        return w;
    endfunction

    function automatic addr_t align(input addr_t a, input size_t sz);
        addr_t aligned;
        aligned = a;
        if (sz == SIZE_HALF) begin
            aligned[0] = 1'b0;
        end else if (sz == SIZE_WORD) begin
            aligned[1:0] = 2'b00;
        end
        return aligned;
    endfunction

    task automatic shadow_write(input addr_t a, input size_t sz, input word_t d);
        shadow[shadow_index(a)] = merge_write(shadow[shadow_index(a)], sz, a[1:0], d);
    endtask

    task automatic access(input logic is_write, input size_t sz, input addr_t a,
                          input word_t d);
        @(negedge clk);
        cur_wr       = is_write;
        cur_addr     = a;
        expect_word  = shadow[shadow_index(a)];
        if (is_write) begin
            expect_word = merge_write(expect_word, sz, a[1:0], d);
        end
        hit_expected = line_valid && (line_tag == line_tag_of(a));
        req          = 1'b1;
        wr           = is_write;
        size         = sz;
        addr         = a;
        wdata        = d;
        issued++;
        #1;
        // previous burst may still be running
        while (!addr_ok) begin
            @(negedge clk);
            #1;
        end
        if (data_ok) begin
            hits++;
            @(negedge clk);
            req = 1'b0;
        end else begin
            misses++;
            @(negedge clk);
            req         = 1'b0;
            outstanding = 1'b1;
            #1;
            while (!data_ok) begin
                @(negedge clk);
                #1;
            end
            @(negedge clk);
            outstanding = 1'b0;
            line_valid  = 1'b1;
            line_tag    = line_tag_of(a);
        end
        if (is_write) begin
            shadow_write(a, sz, d);
        end
    endtask

    idle_after_reset: assert property (@(posedge clk) disable iff (reset)
        issued == 0 |-> addr_ok && !data_ok)
        else begin
            errors++;
            $display("MISMATCH at %0t: before any request addr_ok=%b data_ok=%b",
                     $time, $sampled(addr_ok), $sampled(data_ok));
        end

    stray_data_ok: assert property (@(posedge clk) disable iff (reset)
        !req && !outstanding |-> !data_ok)
        else begin
            errors++;
            $display("MISMATCH at %0t: data_ok with no request pending", $time);
        end

    hit_same_cycle: assert property (@(posedge clk) disable iff (reset)
        req && addr_ok |-> data_ok == hit_expected)
        else begin
            errors++;
            $display("MISMATCH at %0t: access to %h gave data_ok=%b on acceptance, expected %b",
                     $time, cur_addr, $sampled(data_ok), hit_expected);
        end

    no_accept_during_miss: assert property (@(posedge clk) disable iff (reset)
        outstanding |-> !addr_ok)
        else begin
            errors++;
            $display("MISMATCH at %0t: addr_ok high while the miss to %h is open",
                     $time, cur_addr);
        end

    // a write miss hands back its merged beat
    returned_data: assert property (@(posedge clk) disable iff (reset)
        data_ok && (!cur_wr || outstanding) |-> rdata == expect_word)
        else begin
            errors++;
            $display("MISMATCH at %0t: access to %h returned %h, expected %h",
                     $time, cur_addr, $sampled(rdata), expect_word);
        end

    // allowance grows with every request handed to the DUT
    always @(posedge clk) begin
        cycles++;
        if (cycles > RESET_CYCLES + 4 * WORST_CYCLES * (issued + 1)) begin
            $display("timeout: the line buffer stopped answering after %0d cycles", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        addr_t       lines [4];
        addr_t       a;
        size_t       sz;
        logic [31:0] r;

        errors       = 0;
        issued       = 0;
        hits         = 0;
        misses       = 0;
        cycles       = 0;
        rng_state    = 32'hf36fde62;
        reset        = 1'b1;
        req          = 1'b0;
        wr           = 1'b0;
        size         = SIZE_WORD;
        addr         = '0;
        wdata        = '0;
        cur_wr       = 1'b0;
        cur_addr     = '0;
        expect_word  = '0;
        hit_expected = 1'b0;
        outstanding  = 1'b0;
        line_valid   = 1'b0;
        line_tag     = '0;
        lines[0]     = LINE_A;
        lines[1]     = LINE_B;
        lines[2]     = LINE_C;
        lines[3]     = LINE_D;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = initial_word(i);
        end

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (3) @(negedge clk);

        // cold read miss, then hits across the line
        access(1'b0, SIZE_WORD, LINE_A + 32'h24, '0);
        for (int i = 0; i < 8; i++) begin
            r = next_random();
            access(1'b0, SIZE_WORD, align(LINE_A + addr_t'((r >> 8) % LINE_BYTES), SIZE_WORD),
                   '0);
        end

        // strobed write hits with random data on every lane
        access(1'b1, SIZE_BYTE, LINE_A + 32'h05, next_random());
        access(1'b1, SIZE_HALF, LINE_A + 32'h0a, next_random());
        access(1'b1, SIZE_WORD, LINE_A + 32'h30, next_random());
        access(1'b1, SIZE_BYTE, LINE_A + 32'h33, next_random());
        access(1'b1, SIZE_HALF, LINE_A + 32'h3c, next_random());
        access(1'b0, SIZE_WORD, LINE_A + 32'h04, '0);
        access(1'b0, SIZE_WORD, LINE_A + 32'h08, '0);
        access(1'b0, SIZE_WORD, LINE_A + 32'h30, '0);
        access(1'b0, SIZE_WORD, LINE_A + 32'h3c, '0);

        // dirty line goes back to memory, then comes home again
        access(1'b0, SIZE_WORD, LINE_B + 32'h10, '0);
        access(1'b0, SIZE_WORD, LINE_A + 32'h30, '0);
        access(1'b0, SIZE_WORD, LINE_A + 32'h04, '0);
        access(1'b0, SIZE_WORD, LINE_A + 32'h08, '0);

        // write misses on a clean line and on a dirty line
        access(1'b1, SIZE_BYTE, LINE_C + 32'h13, next_random());
        access(1'b0, SIZE_WORD, LINE_C + 32'h10, '0);
        access(1'b0, SIZE_WORD, LINE_C + 32'h0c, '0);
        access(1'b0, SIZE_WORD, LINE_C + 32'h14, '0);
        access(1'b1, SIZE_HALF, LINE_D + 32'h22, next_random());
        access(1'b0, SIZE_WORD, LINE_D + 32'h20, '0);
        access(1'b0, SIZE_WORD, LINE_D + 32'h1c, '0);
        access(1'b0, SIZE_WORD, LINE_D + 32'h24, '0);
        access(1'b0, SIZE_WORD, LINE_C + 32'h10, '0);

        for (int i = 0; i < RANDOM_ACCESSES; i++) begin
            r = next_random();
            case (r[28:27])
                2'd0:    sz = SIZE_BYTE;
                2'd1:    sz = SIZE_HALF;
                default: sz = SIZE_WORD;
            endcase
            a = align(lines[r[31:30]] + addr_t'((r >> 8) % LINE_BYTES), sz);
            access(r[29], sz, a, next_random());
        end

        repeat (4) @(negedge clk);
        $display("requests %0d, hits %0d, misses %0d, errors %0d",
                 issued, hits, misses, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
